/* src/tile_mem_pkg.sv */
//////////////////////////////
// shared widths, DMA command structs and data-memory port opcodes
// for the tile memory front end and its testbench
//////////////////////////////
package tile_mem_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  // DMA data beat
  localparam int data_width = 64;
  // DMA byte address, msb picks imem
  localparam int addr_width = 16;
  // one strobe per byte
  localparam int strb_width = data_width / 8;
  // send descriptor, also the completion message
  localparam int desc_width = 64;

  //////////////////////////////
  // DMA commands
  //////////////////////////////

  // write beat from the DMA engine
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    // burst end
    logic                  last;
  } mem_wr_cmd_t;

  // read request from the DMA engine
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic                  last;
  } mem_rd_cmd_t;

  //////////////////////////////
  // data-memory port op
  //////////////////////////////

  // write and read are bitwise inverses of each other
  typedef enum logic [1:0] {
    op_idle  = 2'b00,
    op_write = 2'b01,
    op_read  = 2'b10
  } dmem_op_e;

endpackage

/* src/local_ram.sv */
//////////////////////////////
// byte-strobed synchronous RAM, one-cycle read, plus a read-only
// second port; used for both data and instruction memory
//////////////////////////////
module local_ram #(
  parameter int WORDS = 1024
) (
  input  logic                                clk,
  input  logic                                en,
  input  logic [tile_mem_pkg::strb_width-1:0] wen,
  input  logic [tile_mem_pkg::addr_width-1:0] addr,
  input  logic [tile_mem_pkg::data_width-1:0] wdata,
  output logic [tile_mem_pkg::data_width-1:0] rdata,
  input  logic [tile_mem_pkg::addr_width-1:0] rd_addr,
  output logic [tile_mem_pkg::data_width-1:0] rd_data
);

  // byte offset bits inside a word
  localparam int lsb   = $clog2(tile_mem_pkg::strb_width);
  localparam int idx_w = $clog2(WORDS);

  logic [tile_mem_pkg::data_width-1:0] mem [WORDS];
  logic [idx_w-1:0]                    idx;
  logic [idx_w-1:0]                    rd_idx;

  // word index from byte address
  assign idx    = addr[lsb +: idx_w];
  assign rd_idx = rd_addr[lsb +: idx_w];

  // main port
  // byte-masked write, read data only moves on a non-write access
  // so a stalled response stays put
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < tile_mem_pkg::strb_width; i++) begin
        if (wen[i]) begin
          mem[idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
      if (wen == '0) begin
        rdata <= mem[idx];
      end
    end
  end

  // second port, free running
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_idx];
  end

endmodule

/* src/dmem_arbiter.sv */
//////////////////////////////
// splits DMA commands between imem and dmem, and shares the single
// dmem port between reads and writes
//////////////////////////////
module dmem_arbiter #(
  parameter int INTERLEAVE = 0
) (
  input  logic                                clk,
  input  logic                                rst,
  input  tile_mem_pkg::mem_wr_cmd_t           wr_cmd,
  input  logic                                wr_valid,
  output logic                                wr_ready,
  input  tile_mem_pkg::mem_rd_cmd_t           rd_cmd,
  input  logic                                rd_valid,
  output logic                                rd_ready,
  output logic                                rd_resp_valid,
  input  logic                                rd_resp_ready,
  output logic                                dmem_en,
  output logic [tile_mem_pkg::strb_width-1:0] dmem_wen,
  output logic [tile_mem_pkg::addr_width-1:0] dmem_addr,
  output logic [tile_mem_pkg::strb_width-1:0] imem_wen,
  output logic [tile_mem_pkg::addr_width-1:0] imem_addr,
  output logic [tile_mem_pkg::data_width-1:0] mem_wdata
);

  localparam int aw = tile_mem_pkg::addr_width;

  logic                   read_reject;
  logic                   imem_wr_en;
  logic                   dmem_wr_en;
  logic                   dmem_rd_en;
  logic                   switch_q;
  logic                   acc_q;
  logic                   rej_q;
  tile_mem_pkg::dmem_op_e dmem_op;
  tile_mem_pkg::dmem_op_e last_op_q;

  //////////////////////////////
  // address split
  //////////////////////////////

  // response held and not taken, so no new read
  assign read_reject = rd_resp_valid && !rd_resp_ready;

  // msb set on a write means imem
  assign imem_wr_en = wr_valid && wr_cmd.addr[aw-1];
  assign dmem_wr_en = wr_valid && !wr_cmd.addr[aw-1];
  // reads always land in dmem, msb is dropped below
  assign dmem_rd_en = rd_valid && !read_reject;

  //////////////////////////////
  // dmem arbitration
  //////////////////////////////

  always_comb begin
    case ({dmem_wr_en, dmem_rd_en})
      2'b00:   dmem_op = tile_mem_pkg::op_idle;
      2'b01:   dmem_op = tile_mem_pkg::op_read;
      2'b10:   dmem_op = tile_mem_pkg::op_write;
      default: begin
        // both pending
        if (last_op_q == tile_mem_pkg::op_idle) begin
          dmem_op = tile_mem_pkg::op_write;
        end else if ((INTERLEAVE != 0) || switch_q) begin
          dmem_op = (last_op_q == tile_mem_pkg::op_write) ?
                    tile_mem_pkg::op_read : tile_mem_pkg::op_write;
        end else begin
          // stay on the current burst
          dmem_op = last_op_q;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_op_q <= tile_mem_pkg::op_idle;
      switch_q  <= 1'b0;
      acc_q     <= 1'b0;
      rej_q     <= 1'b0;
    end else begin
      last_op_q <= dmem_op;
      // a beat with last went through, other side may go next
      switch_q  <= ((dmem_op == tile_mem_pkg::op_write) && wr_cmd.last) ||
                   ((dmem_op == tile_mem_pkg::op_read) && rd_cmd.last);
      acc_q     <= (dmem_op == tile_mem_pkg::op_read);
      rej_q     <= read_reject;
    end
  end

  //////////////////////////////
  // memory ports
  //////////////////////////////

  assign dmem_wen  = (dmem_op == tile_mem_pkg::op_write) ? wr_cmd.strb : '0;
  // zero-strobe write is a no-op, keep rdata unchanged then
  assign dmem_en   = (dmem_op == tile_mem_pkg::op_read) || (dmem_wen != '0);
  assign dmem_addr = (dmem_op == tile_mem_pkg::op_write) ?
                     {1'b0, wr_cmd.addr[aw-2:0]} : {1'b0, rd_cmd.addr[aw-2:0]};
  assign imem_wen  = imem_wr_en ? wr_cmd.strb : '0;
  assign imem_addr = {1'b0, wr_cmd.addr[aw-2:0]};
  assign mem_wdata = wr_cmd.data;

  //////////////////////////////
  // handshakes
  //////////////////////////////

  // valid one cycle after accept, or still held from a stall
  assign rd_resp_valid = acc_q || rej_q;
  assign rd_ready      = (dmem_op == tile_mem_pkg::op_read);
  // imem writes never wait
  assign wr_ready      = wr_cmd.addr[aw-1] || (dmem_op == tile_mem_pkg::op_write);

  // single port never idles while a dmem write waits
  // only a read holds the write off
  wr_wait_read_a: assert property (@(posedge clk) disable iff (rst)
    (dmem_wr_en && !wr_ready) |-> (dmem_op == tile_mem_pkg::op_read));

  // response side comes out of reset quiet
  resp_quiet_a: assert property (@(posedge clk) rst |=> !rd_resp_valid);

endmodule

/* src/desc_fifo.sv */
//////////////////////////////
// small valid/ready FIFO for descriptors, circular buffer with a count
//////////////////////////////
module desc_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [tile_mem_pkg::desc_width-1:0] din,
  input  logic                                din_valid,
  output logic                                din_ready,
  output logic [tile_mem_pkg::desc_width-1:0] dout,
  output logic                                dout_valid,
  input  logic                                dout_ready
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);

  logic [tile_mem_pkg::desc_width-1:0] store [DEPTH];
  logic [ptr_w-1:0]                    wr_ptr;
  logic [ptr_w-1:0]                    rd_ptr;
  logic [cnt_w-1:0]                    count;
  logic                                push;
  logic                                pop;

  // full when count hits depth
  assign din_ready  = (count != cnt_w'(DEPTH));
  assign dout_valid = (count != '0);
  assign dout       = store[rd_ptr];

  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  // payload
  always_ff @(posedge clk) begin
    if (push) begin
      store[wr_ptr] <= din;
    end
  end

  // pointers wrap at depth, not at a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // count never runs past depth
  // pointers meet only when empty or full
  fill_state_a: assert property (@(posedge clk) disable iff (rst)
    (count <= cnt_w'(DEPTH)) &&
    ((wr_ptr == rd_ptr) == ((count == '0) || (count == cnt_w'(DEPTH)))));

endmodule

/* src/tile_ctrl.sv */
//////////////////////////////
// core reset command, send-descriptor queue and completion messages
//////////////////////////////
module tile_ctrl #(
  parameter int DESC_DEPTH = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [tile_mem_pkg::data_width-1:0] ctrl_in_data,
  input  logic                                ctrl_in_valid,
  output logic                                ctrl_in_ready,
  output logic                                core_reset,
  input  logic [tile_mem_pkg::desc_width-1:0] send_desc_in,
  input  logic                                send_desc_in_valid,
  output logic                                send_desc_in_ready,
  output logic [tile_mem_pkg::desc_width-1:0] send_desc_out,
  output logic                                send_desc_out_valid,
  input  logic                                send_desc_out_ready,
  input  logic                                pkt_sent,
  output logic [tile_mem_pkg::desc_width-1:0] ctrl_out_data,
  output logic                                ctrl_out_valid,
  input  logic                                ctrl_out_ready
);

  logic                                reset_cmd;
  logic                                desc_take;
  logic                                done_ready;
  logic [tile_mem_pkg::desc_width-1:0] taken_desc;

  //////////////////////////////
  // core reset
  //////////////////////////////

  // top addr_width bits all ones marks a reset command
  assign reset_cmd = ctrl_in_valid &&
    (&ctrl_in_data[tile_mem_pkg::data_width-1 -: tile_mem_pkg::addr_width]);
  assign ctrl_in_ready = 1'b1;

  // core held in reset until told otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      core_reset <= 1'b1;
    end else if (reset_cmd) begin
      core_reset <= ctrl_in_data[0];
    end
  end

  //////////////////////////////
  // descriptors
  //////////////////////////////

  // core to DMA
  desc_fifo #(.DEPTH(DESC_DEPTH)) send_q (
    .clk       (clk),
    .rst       (rst),
    .din       (send_desc_in),
    .din_valid (send_desc_in_valid),
    .din_ready (send_desc_in_ready),
    .dout      (send_desc_out),
    .dout_valid(send_desc_out_valid),
    .dout_ready(send_desc_out_ready)
  );

  // last descriptor the DMA took, returned once its packet is out
  assign desc_take = send_desc_out_valid && send_desc_out_ready;

  always_ff @(posedge clk) begin
    if (desc_take) begin
      taken_desc <= send_desc_out;
    end
  end

  // completions, one beat each
  desc_fifo #(.DEPTH(DESC_DEPTH)) done_q (
    .clk       (clk),
    .rst       (rst),
    .din       (taken_desc),
    .din_valid (pkt_sent),
    .din_ready (done_ready),
    .dout      (ctrl_out_data),
    .dout_valid(ctrl_out_valid),
    .dout_ready(ctrl_out_ready)
  );

  // a completion is never dropped
  done_room_a: assert property (@(posedge clk) disable iff (rst)
    pkt_sent |-> done_ready);

endmodule

/* src/tile_mem_front.sv */
//////////////////////////////
// local-memory front end of the core tile, sits between the packet
// DMA engine and the core; instances and wires only
//////////////////////////////
module tile_mem_front #(
  parameter int INTERLEAVE = 0,
  parameter int DMEM_WORDS = 4096,
  parameter int IMEM_WORDS = 1024,
  parameter int DESC_DEPTH = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  // DMA side
  input  tile_mem_pkg::mem_wr_cmd_t           wr_cmd,
  input  logic                                wr_valid,
  output logic                                wr_ready,
  input  tile_mem_pkg::mem_rd_cmd_t           rd_cmd,
  input  logic                                rd_valid,
  output logic                                rd_ready,
  output logic [tile_mem_pkg::data_width-1:0] rd_resp_data,
  output logic                                rd_resp_valid,
  input  logic                                rd_resp_ready,
  // control
  input  logic [tile_mem_pkg::data_width-1:0] ctrl_in_data,
  input  logic                                ctrl_in_valid,
  output logic                                ctrl_in_ready,
  output logic [tile_mem_pkg::desc_width-1:0] ctrl_out_data,
  output logic                                ctrl_out_valid,
  input  logic                                ctrl_out_ready,
  output logic                                core_reset,
  // descriptors
  input  logic [tile_mem_pkg::desc_width-1:0] send_desc_in,
  input  logic                                send_desc_in_valid,
  output logic                                send_desc_in_ready,
  output logic [tile_mem_pkg::desc_width-1:0] send_desc_out,
  output logic                                send_desc_out_valid,
  input  logic                                send_desc_out_ready,
  input  logic                                pkt_sent,
  // core fetch
  input  logic [tile_mem_pkg::addr_width-1:0] imem_fetch_addr,
  output logic [tile_mem_pkg::data_width-1:0] imem_fetch_data
);

  logic                                dmem_en;
  logic [tile_mem_pkg::strb_width-1:0] dmem_wen;
  logic [tile_mem_pkg::addr_width-1:0] dmem_addr;
  logic [tile_mem_pkg::strb_width-1:0] imem_wen;
  logic [tile_mem_pkg::addr_width-1:0] imem_addr;
  logic [tile_mem_pkg::data_width-1:0] mem_wdata;

  // split and arbitrate
  dmem_arbiter #(.INTERLEAVE(INTERLEAVE)) arb (
    .clk(clk), .rst(rst),
    .wr_cmd(wr_cmd), .wr_valid(wr_valid), .wr_ready(wr_ready),
    .rd_cmd(rd_cmd), .rd_valid(rd_valid), .rd_ready(rd_ready),
    .rd_resp_valid(rd_resp_valid), .rd_resp_ready(rd_resp_ready),
    .dmem_en(dmem_en), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
    .imem_wen(imem_wen), .imem_addr(imem_addr), .mem_wdata(mem_wdata)
  );

  // data memory, response data straight from the RAM register
  local_ram #(.WORDS(DMEM_WORDS)) dmem_ram (
    .clk(clk), .en(dmem_en), .wen(dmem_wen), .addr(dmem_addr),
    .wdata(mem_wdata), .rdata(rd_resp_data),
    .rd_addr(), .rd_data()
  );

  // instruction memory, DMA writes in, core fetches out
  local_ram #(.WORDS(IMEM_WORDS)) imem_ram (
    .clk(clk), .en(1'b1), .wen(imem_wen), .addr(imem_addr),
    .wdata(mem_wdata), .rdata(),
    .rd_addr(imem_fetch_addr), .rd_data(imem_fetch_data)
  );

  // reset command and descriptor path
  tile_ctrl #(.DESC_DEPTH(DESC_DEPTH)) ctrl (
    .clk(clk), .rst(rst),
    .ctrl_in_data(ctrl_in_data), .ctrl_in_valid(ctrl_in_valid),
    .ctrl_in_ready(ctrl_in_ready), .core_reset(core_reset),
    .send_desc_in(send_desc_in), .send_desc_in_valid(send_desc_in_valid),
    .send_desc_in_ready(send_desc_in_ready),
    .send_desc_out(send_desc_out), .send_desc_out_valid(send_desc_out_valid),
    .send_desc_out_ready(send_desc_out_ready),
    .pkt_sent(pkt_sent),
    .ctrl_out_data(ctrl_out_data), .ctrl_out_valid(ctrl_out_valid),
    .ctrl_out_ready(ctrl_out_ready)
  );

endmodule

/* sim/tb_tile_mem_front.sv */
//////////////////////////////
// table-driven testbench for the tile memory front end, rows applied in
// order against a shadow model of both memories and the descriptor path
//////////////////////////////
module tb_tile_mem_front;
  timeunit 1ns;
  timeprecision 1ps;

  // row kinds
  typedef enum logic [2:0] {k_write, k_read, k_both, k_ctrl, k_desc, k_fetch} kind_e;

  // one stimulus row, addr2 is the read side of a both row
  typedef struct packed {
    kind_e       kind;
    logic [15:0] addr;
    logic [15:0] addr2;
    int          beats;
    logic [7:0]  strb;
    int          stall;
    logic [63:0] data;
    logic [63:0] exp_val;
  } row_t;

  logic                      clk;
  logic                      rst;
  tile_mem_pkg::mem_wr_cmd_t wr_cmd;
  logic                      wr_valid;
  logic                      wr_ready;
  tile_mem_pkg::mem_rd_cmd_t rd_cmd;
  logic                      rd_valid;
  logic                      rd_ready;
  logic [63:0]               rd_resp_data;
  logic                      rd_resp_valid;
  logic                      rd_resp_ready;
  logic [63:0]               ctrl_in_data;
  logic                      ctrl_in_valid;
  logic                      ctrl_in_ready;
  logic [63:0]               ctrl_out_data;
  logic                      ctrl_out_valid;
  logic                      ctrl_out_ready;
  logic                      core_reset;
  logic [63:0]               send_desc_in;
  logic                      send_desc_in_valid;
  logic                      send_desc_in_ready;
  logic [63:0]               send_desc_out;
  logic                      send_desc_out_valid;
  logic                      send_desc_out_ready;
  logic                      pkt_sent;
  logic [15:0]               imem_fetch_addr;
  logic [63:0]               imem_fetch_data;

  // shadow of both memories, keyed by word address with the imem bit on top
  logic [63:0] shadow [logic [12:0]];
  row_t        rows[$];
  string       row_name[$];
  int          cycles;
  int          desc_pending;

  tile_mem_front #(
    .INTERLEAVE(0), .DMEM_WORDS(4096), .IMEM_WORDS(1024), .DESC_DEPTH(4)
  ) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog, 20 cycles per row plus reset slack
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > 20 * rows.size() + 50) begin
        $display("run timed out after %0d cycles", cycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
      end
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic flag_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  function automatic void add_row(input string name, input kind_e kind, input logic [15:0] addr,
                                  input logic [15:0] addr2, input int beats, input logic [7:0] strb,
                                  input int stall, input logic [63:0] data, input logic [63:0] ev);
    row_t r;
    r = '{kind, addr, addr2, beats, strb, stall, data, ev};
    rows.push_back(r);
    row_name.push_back(name);
  endfunction

  // byte-masked merge into the shadow
  function automatic void merge_write(input logic [15:0] a, input logic [63:0] d,
                                      input logic [7:0] s);
    logic [63:0] w;
    w = shadow.exists(a[15:3]) ? shadow[a[15:3]] : 64'bx;
    for (int i = 0; i < 8; i++) begin
      if (s[i]) begin
        w[8*i +: 8] = d[8*i +: 8];
      end
    end
    shadow[a[15:3]] = w;
  endfunction

  function automatic logic [63:0] expected_word(input logic [15:0] a);
    if (shadow.exists(a[15:3])) begin
      return shadow[a[15:3]];
    end
    return 64'bx;
  endfunction

  //////////////////////////////
  // row tasks
  //////////////////////////////

  // write and read streams side by side, read stall on the second response
  task automatic burst_transfer(input string name, input logic [15:0] wa, input int wbeats,
                                input logic [7:0] strb, input logic [15:0] ra, input int rbeats,
                                input int stall);
    int          wdone;
    int          rissued;
    int          rgot;
    int          stall_left;
    logic        acc_prev;
    logic        held_prev;
    logic [63:0] held_data;
    logic [63:0] wdata;
    logic [63:0] exp_word;
    logic [63:0] exp_q[$];
    wdone = 0;
    rissued = 0;
    rgot = 0;
    stall_left = stall;
    acc_prev = 1'b0;
    held_prev = 1'b0;
    held_data = '0;
    wdata = {$urandom, $urandom};
    while (wdone < wbeats || rgot < rbeats) begin
      wr_valid = (wdone < wbeats);
      wr_cmd.addr = wa + 16'(wdone * 8);
      wr_cmd.data = wdata;
      wr_cmd.strb = strb;
      wr_cmd.last = (wdone == wbeats - 1);
      rd_valid = (rissued < rbeats);
      rd_cmd.addr = ra + 16'(rissued * 8);
      rd_cmd.last = (rissued == rbeats - 1);
      rd_resp_ready = !(rgot == 1 && stall_left > 0);
      #2;
      // valid exactly one cycle after accept, or held from a stall
      assert (rd_resp_valid == (acc_prev || held_prev))
        else abort_run({name, ": read response valid at the wrong time"});
      if (held_prev) begin
        assert (rd_resp_data === held_data) else flag_mismatch(name, held_data, rd_resp_data);
      end
      if (rd_resp_valid && !rd_resp_ready) begin
        assert (!rd_ready) else abort_run({name, ": read accepted while response stalled"});
        stall_left--;
      end
      held_prev = rd_resp_valid && !rd_resp_ready;
      held_data = rd_resp_data;
      if (rd_resp_valid && rd_resp_ready) begin
        assert (exp_q.size() > 0) else abort_run({name, ": response with no read outstanding"});
        exp_word = exp_q.pop_front();
        assert (rd_resp_data === exp_word) else flag_mismatch(name, exp_word, rd_resp_data);
        rgot++;
      end
      acc_prev = rd_valid && rd_ready;
      // reads always hit dmem, msb dropped
      if (acc_prev) begin
        exp_q.push_back(expected_word({1'b0, rd_cmd.addr[14:0]}));
        rissued++;
      end
      if (wr_valid && wr_ready) begin
        merge_write(wr_cmd.addr, wdata, strb);
        wdone++;
        wdata = {$urandom, $urandom};
      end
      next_cycle();
    end
    wr_valid = 1'b0;
    rd_valid = 1'b0;
    rd_resp_ready = 1'b1;
  endtask

  task automatic ctrl_command(input string name, input logic [63:0] word, input logic exp_rst);
    ctrl_in_data = word;
    ctrl_in_valid = 1'b1;
    #2;
    assert (ctrl_in_ready) else abort_run({name, ": ctrl_in_ready low"});
    next_cycle();
    ctrl_in_valid = 1'b0;
    #2;
    assert (core_reset === exp_rst) else flag_mismatch(name, 64'(exp_rst), 64'(core_reset));
    next_cycle();
  endtask

  // push, take the oldest, then return it as a completion
  task automatic desc_roundtrip(input string name, input int n_push, input logic [63:0] first,
                                input int stall, input logic [63:0] exp_desc);
    for (int i = 0; i < n_push; i++) begin
      send_desc_in = first + 64'(i);
      send_desc_in_valid = 1'b1;
      #2;
      // empty queue shows nothing in the push cycle
      if (desc_pending == 0) begin
        assert (!send_desc_out_valid) else abort_run({name, ": descriptor passed with no latency"});
      end
      while (!send_desc_in_ready) begin
        next_cycle();
        #2;
      end
      desc_pending++;
      next_cycle();
    end
    send_desc_in_valid = 1'b0;
    send_desc_out_ready = 1'b1;
    #2;
    while (!send_desc_out_valid) begin
      next_cycle();
      #2;
    end
    assert (send_desc_out === exp_desc) else flag_mismatch(name, exp_desc, send_desc_out);
    desc_pending--;
    next_cycle();
    send_desc_out_ready = 1'b0;
    pkt_sent = 1'b1;
    ctrl_out_ready = 1'b0;
    #2;
    assert (!ctrl_out_valid) else abort_run({name, ": completion before pkt_sent"});
    next_cycle();
    pkt_sent = 1'b0;
    // held under back-pressure
    for (int i = 0; i < stall; i++) begin
      #2;
      assert (ctrl_out_valid) else abort_run({name, ": completion dropped during stall"});
      assert (ctrl_out_data === exp_desc) else flag_mismatch(name, exp_desc, ctrl_out_data);
      next_cycle();
    end
    ctrl_out_ready = 1'b1;
    #2;
    assert (ctrl_out_valid) else abort_run({name, ": no completion one cycle after pkt_sent"});
    assert (ctrl_out_data === exp_desc) else flag_mismatch(name, exp_desc, ctrl_out_data);
    next_cycle();
    ctrl_out_ready = 1'b0;
  endtask

  task automatic fetch_check(input string name, input logic [15:0] a);
    logic [63:0] exp_word;
    imem_fetch_addr = a;
    exp_word = expected_word({1'b1, a[14:0]});
    next_cycle();
    #2;
    assert (imem_fetch_data === exp_word) else flag_mismatch(name, exp_word, imem_fetch_data);
    next_cycle();
  endtask

  //////////////////////////////
  // stimulus table and main loop
  //////////////////////////////

  initial begin
    row_t r;
    void'($urandom(32'h9579));
    desc_pending = 0;
    rst = 1'b1;
    wr_cmd = '0;
    wr_valid = 1'b0;
    rd_cmd = '0;
    rd_valid = 1'b0;
    rd_resp_ready = 1'b1;
    ctrl_in_data = '0;
    ctrl_in_valid = 1'b0;
    ctrl_out_ready = 1'b0;
    send_desc_in = '0;
    send_desc_in_valid = 1'b0;
    send_desc_out_ready = 1'b0;
    pkt_sent = 1'b0;
    imem_fetch_addr = '0;

    // name, kind, addr, addr2, beats, strb, stall, data, expected
    add_row("ctrl_no_prefix", k_ctrl, 16'h0, 16'h0, 0, 8'h0, 0, 64'h1234_0000_0000_0000, 64'h1);
    add_row("ctrl_clear_rst", k_ctrl, 16'h0, 16'h0, 0, 8'h0, 0, 64'hffff_0000_0000_0000, 64'h0);
    add_row("ctrl_no_prefix2", k_ctrl, 16'h0, 16'h0, 0, 8'h0, 0, 64'h7fff_0000_0000_0001, 64'h0);
    add_row("dmem_fill", k_write, 16'h0100, 16'h0, 8, 8'hff, 0, 64'h0, 64'h0);
    add_row("dmem_partial", k_write, 16'h0100, 16'h0, 8, 8'h5a, 0, 64'h0, 64'h0);
    add_row("dmem_readback", k_read, 16'h0100, 16'h0, 8, 8'h0, 0, 64'h0, 64'h0);
    add_row("imem_fill", k_write, 16'h8100, 16'h0, 4, 8'hff, 0, 64'h0, 64'h0);
    add_row("imem_partial", k_write, 16'h8108, 16'h0, 2, 8'hf0, 0, 64'h0, 64'h0);
    add_row("dmem_after_imem", k_read, 16'h0100, 16'h0, 4, 8'h0, 0, 64'h0, 64'h0);
    add_row("imem_fetch0", k_fetch, 16'h0100, 16'h0, 0, 8'h0, 0, 64'h0, 64'h0);
    add_row("imem_fetch2", k_fetch, 16'h0110, 16'h0, 0, 8'h0, 0, 64'h0, 64'h0);
    add_row("read_stall", k_read, 16'h0100, 16'h0, 8, 8'h0, 4, 64'h0, 64'h0);
    add_row("dmem_region_b", k_write, 16'h0400, 16'h0, 8, 8'hff, 0, 64'h0, 64'h0);
    add_row("rd_wr_together", k_both, 16'h0800, 16'h0400, 8, 8'hff, 0, 64'h0, 64'h0);
    add_row("read_region_c", k_read, 16'h0800, 16'h0, 8, 8'h0, 0, 64'h0, 64'h0);
    add_row("read_imem_half", k_read, 16'h8400, 16'h0, 2, 8'h0, 0, 64'h0, 64'h0);
    add_row("desc_first", k_desc, 16'h0, 16'h0, 3, 8'h0, 0, 64'hd0d0_0000_0000_1000,
            64'hd0d0_0000_0000_1000);
    add_row("desc_second", k_desc, 16'h0, 16'h0, 0, 8'h0, 3, 64'h0, 64'hd0d0_0000_0000_1001);
    add_row("desc_third", k_desc, 16'h0, 16'h0, 0, 8'h0, 5, 64'h0, 64'hd0d0_0000_0000_1002);

    // reset for 4 cycles
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    #2;
    assert (core_reset && !rd_resp_valid && !send_desc_out_valid && !ctrl_out_valid)
      else abort_run("outputs not at their reset values after reset");
    next_cycle();

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      case (r.kind)
        k_write: burst_transfer(row_name[i], r.addr, r.beats, r.strb, 16'h0, 0, 0);
        k_read:  burst_transfer(row_name[i], 16'h0, 0, 8'h0, r.addr, r.beats, r.stall);
        k_both:  burst_transfer(row_name[i], r.addr, r.beats, r.strb, r.addr2, r.beats, r.stall);
        k_ctrl:  ctrl_command(row_name[i], r.data, r.exp_val[0]);
        k_desc:  desc_roundtrip(row_name[i], r.beats, r.data, r.stall, r.exp_val);
        k_fetch: fetch_check(row_name[i], r.addr);
        default: abort_run("unknown row kind in the stimulus table");
      endcase
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* all.f */
src/tile_mem_pkg.sv
src/local_ram.sv
src/dmem_arbiter.sv
src/desc_fifo.sv
src/tile_ctrl.sv
src/tile_mem_front.sv
sim/tb_tile_mem_front.sv

/* run.sh */
#!/usr/bin/env bash
# build the tile memory front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_tile_mem_front -f all.f -o tb_sim

# the exit status of tee is kept, the log decides the result
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
